// File: isa_pkg.sv
package isa_pkg;

        typedef struct packed {
                logic [16:0] op;
                logic [4:0]  rk;
                logic [4:0]  rj;
                logic [4:0]  rd;
        } inst_r3_t;

        typedef struct packed {
                logic [9:0]  op;
                logic [11:0] si12;
                logic [4:0]  rj;
                logic [4:0]  rd;
        } inst_ri12_t;

        // rj and rd sit at the same bits in both views.
        typedef union packed {
                inst_r3_t   r3;
                inst_ri12_t ri12;
        } inst_u;

        localparam logic [16:0] OP_ADD_W  = 17'h00020;
        localparam logic [16:0] OP_SUB_W  = 17'h00022;
        localparam logic [16:0] OP_AND    = 17'h00029;
        localparam logic [16:0] OP_OR     = 17'h0002a;

        localparam logic [9:0]  OP_ADDI_W = 10'h00a;
        localparam logic [9:0]  OP_LD_W   = 10'h0a2;
        localparam logic [9:0]  OP_ST_W   = 10'h0a6;

        typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} alu_op_t;

endpackage

// File: pipe_pkg.sv
package pipe_pkg;

        localparam int XLEN = 32;

        // register file geometry.
        localparam int RA_W  = 5;
        localparam int NREGS = 2 ** RA_W;

        // the word index of the data ram comes from byte address bits 9..2.
        localparam int RAM_WORDS = 256;
        localparam int RAM_AW    = $clog2(RAM_WORDS);

        // response delay of the ram in cycles after the request is seen.
        localparam int LAT_MIN = 1;
        localparam int LAT_MAX = 4;
        localparam int LAT_W   = $clog2(LAT_MAX + 1);

        localparam logic [15:0] LFSR_SEED = 16'hace1;

endpackage

// File: ex_stage.sv
`timescale 1ns/1ps

module ex_stage import isa_pkg::*, pipe_pkg::*; (
        input  logic            clk,
        input  logic            rst,
        input  logic            issue_valid,
        input  logic [XLEN-1:0] issue_pc,
        input  logic [XLEN-1:0] issue_ir,
        output logic            issue_allowin,
        input  logic            mem_allowin,
        output logic [RA_W-1:0] rf_raddr1,
        output logic [RA_W-1:0] rf_raddr2,
        input  logic [XLEN-1:0] rf_rdata1,
        input  logic [XLEN-1:0] rf_rdata2,
        input  logic            fwd_mem_valid,
        input  logic [RA_W-1:0] fwd_mem_addr,
        input  logic [XLEN-1:0] fwd_mem_data,
        input  logic            mem_ld_pending,
        input  logic [RA_W-1:0] mem_ld_addr,
        input  logic            fwd_wb_valid,
        input  logic [RA_W-1:0] fwd_wb_addr,
        input  logic [XLEN-1:0] fwd_wb_data,
        output logic            em_valid,
        output logic [XLEN-1:0] em_pc,
        output logic [XLEN-1:0] em_ir,
        output logic            em_ld,
        output logic            em_st,
        output logic            em_gr_we,
        output logic [XLEN-1:0] em_rkd,
        output logic [RA_W-1:0] em_waddr,
        output logic [XLEN-1:0] em_alu
);

        logic            ex_valid;
        logic [XLEN-1:0] ex_pc;
        inst_u           ex_ir;
        logic            is_sub;
        logic            is_and;
        logic            is_or;
        logic            is_ld;
        logic            is_st;
        logic            use_rk;
        logic [RA_W-1:0] src1;
        logic [RA_W-1:0] src2;
        logic            stall;
        logic            ex_go;
        logic [XLEN-1:0] opnd1;
        logic [XLEN-1:0] opnd2;
        logic [XLEN-1:0] imm;
        alu_op_t         alu_op;
        logic [XLEN-1:0] alu_res;

        function automatic logic [XLEN-1:0] pick(input logic [RA_W-1:0] src,
                                                 input logic [XLEN-1:0] rf_val);
                if (src == '0)
                        return '0;
                if (fwd_mem_valid && fwd_mem_addr == src)
                        return fwd_mem_data;
                if (fwd_wb_valid && fwd_wb_addr == src)
                        return fwd_wb_data;
                return rf_val;
        endfunction

        assign is_sub = (ex_ir.r3.op == OP_SUB_W);
        assign is_and = (ex_ir.r3.op == OP_AND);
        assign is_or  = (ex_ir.r3.op == OP_OR);
        assign is_ld  = (ex_ir.ri12.op == OP_LD_W);
        assign is_st  = (ex_ir.ri12.op == OP_ST_W);
        assign use_rk = (ex_ir.r3.op == OP_ADD_W) | is_sub | is_and | is_or;

        assign src1      = ex_ir.r3.rj;
        assign src2      = is_st ? ex_ir.ri12.rd : ex_ir.r3.rk; // st.w stores rd.
        assign rf_raddr1 = src1;
        assign rf_raddr2 = src2;

        // hold back anything that needs a load result not yet in write-back.
        assign stall = ex_valid & mem_ld_pending &
                       ((src1 != '0 && src1 == mem_ld_addr) |
                        ((use_rk | is_st) && src2 != '0 && src2 == mem_ld_addr));

        assign ex_go         = mem_allowin & ~stall;
        assign issue_allowin = ~ex_valid | ex_go;

        always_comb begin
                opnd1 = pick(src1, rf_rdata1);
                opnd2 = pick(src2, rf_rdata2);
        end

        assign imm = {{(XLEN - 12){ex_ir.ri12.si12[11]}}, ex_ir.ri12.si12};

        always_comb begin
                if (is_sub)
                        alu_op = ALU_SUB;
                else if (is_and)
                        alu_op = ALU_AND;
                else if (is_or)
                        alu_op = ALU_OR;
                else
                        alu_op = ALU_ADD; // addi.w and address generation too.
        end

        always_comb begin
                case (alu_op)
                        ALU_SUB: alu_res = opnd1 - opnd2;
                        ALU_AND: alu_res = opnd1 & opnd2;
                        ALU_OR:  alu_res = opnd1 | opnd2;
                        default: alu_res = opnd1 + (use_rk ? opnd2 : imm);
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst)
                        ex_valid <= 1'b0;
                else if (issue_allowin)
                        ex_valid <= issue_valid;
                if (issue_valid && issue_allowin) begin
                        ex_pc <= issue_pc;
                        ex_ir <= issue_ir;
                end
        end

        always_ff @(posedge clk) begin
                if (rst)
                        em_valid <= 1'b0;
                else if (mem_allowin)
                        em_valid <= ex_valid & ~stall; // a stall sends a bubble.
                if (ex_valid && ex_go) begin
                        em_pc    <= ex_pc;
                        em_ir    <= ex_ir;
                        em_ld    <= is_ld;
                        em_st    <= is_st;
                        em_gr_we <= ~is_st;
                        em_rkd   <= opnd2;
                        em_waddr <= ex_ir.r3.rd;
                        em_alu   <= alu_res;
                end
        end

        a_held_until_go: assert property (@(posedge clk) disable iff (rst)
                (ex_valid && !ex_go) |=> (ex_valid && $stable(ex_pc) && $stable(ex_ir)));

endmodule

// File: mem_stage.sv
`timescale 1ns/1ps

module mem_stage import pipe_pkg::*; (
        input  logic            clk,
        input  logic            rst,
        input  logic            em_valid,
        input  logic [XLEN-1:0] em_pc,
        input  logic [XLEN-1:0] em_ir,
        input  logic            em_ld,
        input  logic            em_st,
        input  logic            em_gr_we,
        input  logic [XLEN-1:0] em_rkd,
        input  logic [RA_W-1:0] em_waddr,
        input  logic [XLEN-1:0] em_alu,
        input  logic            data_ready,
        input  logic            data_valid,
        input  logic [XLEN-1:0] read_data,
        output logic            mem_allowin,
        output logic            req_en,
        output logic [3:0]      req_we,
        output logic [XLEN-1:0] req_addr,
        output logic [XLEN-1:0] req_wdata,
        output logic            fwd_mem_valid,
        output logic [RA_W-1:0] fwd_mem_addr,
        output logic [XLEN-1:0] fwd_mem_data,
        output logic            mem_ld_pending,
        output logic [RA_W-1:0] mem_ld_addr,
        output logic            wb_valid,
        output logic [XLEN-1:0] wb_pc,
        output logic [XLEN-1:0] wb_ir,
        output logic            wb_gr_we,
        output logic [RA_W-1:0] wb_waddr,
        output logic [XLEN-1:0] wb_wdata
);

        logic            mem_op;
        logic            resp_seen;
        logic            done;
        logic [XLEN-1:0] ld_data;
        logic [XLEN-1:0] result;

        assign mem_op = em_ld | em_st;

        // alu work finishes at once, memory work one edge after its response.
        assign done        = em_valid & (~mem_op | resp_seen);
        assign mem_allowin = ~em_valid | done;

        assign req_en    = em_valid & mem_op & ~resp_seen; // dropped after the response.
        assign req_we    = {4{em_valid & em_st}};
        assign req_addr  = em_alu;
        assign req_wdata = em_rkd;

        assign fwd_mem_valid  = em_valid & em_gr_we & ~em_ld;
        assign fwd_mem_addr   = em_waddr;
        assign fwd_mem_data   = em_alu;
        assign mem_ld_pending = em_valid & em_ld; // the loaded word is forwarded from write-back.
        assign mem_ld_addr    = em_waddr;

        always_ff @(posedge clk) begin
                if (rst)
                        resp_seen <= 1'b0;
                else if (done)
                        resp_seen <= 1'b0;
                else if (req_en && (data_ready || data_valid))
                        resp_seen <= 1'b1;
        end

        always_ff @(posedge clk) begin
                if (data_valid)
                        ld_data <= read_data; // the read word is only there for one cycle.
        end

        assign result = em_ld ? ld_data : em_alu;

        always_ff @(posedge clk) begin
                if (rst)
                        wb_valid <= 1'b0;
                else
                        wb_valid <= done; // empty bubble while nothing finishes.
                if (done) begin
                        wb_pc    <= em_pc;
                        wb_ir    <= em_ir;
                        wb_gr_we <= em_gr_we;
                        wb_waddr <= em_waddr;
                        wb_wdata <= result;
                end
        end

        a_resp_needs_req: assert property (@(posedge clk) disable iff (rst)
                (data_ready || data_valid) |-> req_en);

endmodule

// File: wb_stage.sv
`timescale 1ns/1ps

module wb_stage import isa_pkg::*, pipe_pkg::*; (
        input  logic            clk,
        input  logic            rst,
        input  logic            wb_valid,
        input  logic [XLEN-1:0] wb_pc,
        input  logic [XLEN-1:0] wb_ir,
        input  logic            wb_gr_we,
        input  logic [RA_W-1:0] wb_waddr,
        input  logic [XLEN-1:0] wb_wdata,
        output logic            rf_we,
        output logic [RA_W-1:0] rf_waddr,
        output logic [XLEN-1:0] rf_wdata,
        output logic            fwd_wb_valid,
        output logic [RA_W-1:0] fwd_wb_addr,
        output logic [XLEN-1:0] fwd_wb_data,
        output logic            commit_valid,
        output logic [XLEN-1:0] commit_pc,
        output logic [RA_W-1:0] commit_rd,
        output logic            commit_we,
        output logic [XLEN-1:0] commit_wdata
);

        inst_u ir;

        assign ir = wb_ir;

        assign rf_we    = wb_valid & wb_gr_we & (wb_waddr != '0); // r0 is never written.
        assign rf_waddr = wb_waddr;
        assign rf_wdata = wb_wdata;

        assign fwd_wb_valid = rf_we;
        assign fwd_wb_addr  = wb_waddr;
        assign fwd_wb_data  = wb_wdata;

        always_ff @(posedge clk) begin
                if (rst)
                        commit_valid <= 1'b0;
                else
                        commit_valid <= wb_valid;
                commit_pc    <= wb_pc;
                commit_rd    <= ir.r3.rd;
                commit_we    <= rf_we;
                commit_wdata <= wb_wdata;
        end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file import pipe_pkg::*; (
        input  logic            clk,
        input  logic            rst,
        input  logic [RA_W-1:0] raddr1,
        input  logic [RA_W-1:0] raddr2,
        output logic [XLEN-1:0] rdata1,
        output logic [XLEN-1:0] rdata2,
        input  logic            we,
        input  logic [RA_W-1:0] waddr,
        input  logic [XLEN-1:0] wdata
);

        logic [XLEN-1:0] regs [NREGS];

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < NREGS; i++)
                                regs[i] <= '0;
                end else if (we && waddr != '0) begin
                        regs[waddr] <= wdata;
                end
        end

        // a write in this cycle is seen through the write-back forward, not here.
        assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
        assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: data_ram.sv
`timescale 1ns/1ps

module data_ram import pipe_pkg::*; (
        input  logic            clk,
        input  logic            rst,
        input  logic            req_en,
        input  logic [3:0]      req_we,
        input  logic [XLEN-1:0] req_addr,
        input  logic [XLEN-1:0] req_wdata,
        output logic            data_ready,
        output logic            data_valid,
        output logic [XLEN-1:0] read_data
);

        logic [XLEN-1:0]   mem [RAM_WORDS];
        logic [15:0]       lfsr;
        logic [LAT_W-1:0]  delay;
        logic [LAT_W-1:0]  cnt;
        logic [3:0]        we_q;
        logic [RAM_AW-1:0] addr_q;
        logic [XLEN-1:0]   wdata_q;

        assign delay = LAT_W'(LAT_MIN + lfsr % (LAT_MAX - LAT_MIN + 1));

        always_ff @(posedge clk) begin
                if (rst) begin
                        lfsr <= LFSR_SEED;
                        cnt  <= '0;
                        for (int i = 0; i < RAM_WORDS; i++)
                                mem[i] <= '0;
                end else begin
                        lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
                        if (cnt == '0) begin
                                if (req_en) begin // take the request when idle.
                                        cnt     <= delay;
                                        we_q    <= req_we;
                                        addr_q  <= req_addr[RAM_AW+1:2];
                                        wdata_q <= req_wdata;
                                end
                        end else begin
                                cnt <= cnt - 1'b1;
                                if (cnt == 1) begin
                                        for (int b = 0; b < 4; b++)
                                                if (we_q[b])
                                                        mem[addr_q][8*b +: 8] <= wdata_q[8*b +: 8];
                                end
                        end
                end
        end

        // the last count cycle carries the response.
        assign data_ready = (cnt == 1) & (|we_q);
        assign data_valid = (cnt == 1) & ~(|we_q);
        assign read_data  = mem[addr_q];

        a_req_held: assert property (@(posedge clk) disable iff (rst)
                (cnt != '0) |-> (req_en && req_addr[RAM_AW+1:2] == addr_q));

endmodule

// File: la_backend.sv
`timescale 1ns/1ps

module la_backend import pipe_pkg::*; (
        input  logic            clk,
        input  logic            rst,
        input  logic            issue_valid,
        input  logic [XLEN-1:0] issue_pc,
        input  logic [XLEN-1:0] issue_ir,
        output logic            issue_allowin,
        output logic            commit_valid,
        output logic [XLEN-1:0] commit_pc,
        output logic [RA_W-1:0] commit_rd,
        output logic            commit_we,
        output logic [XLEN-1:0] commit_wdata
);

        logic            mem_allowin;
        logic [RA_W-1:0] rf_raddr1;
        logic [RA_W-1:0] rf_raddr2;
        logic [XLEN-1:0] rf_rdata1;
        logic [XLEN-1:0] rf_rdata2;
        logic            fwd_mem_valid;
        logic [RA_W-1:0] fwd_mem_addr;
        logic [XLEN-1:0] fwd_mem_data;
        logic            mem_ld_pending;
        logic [RA_W-1:0] mem_ld_addr;
        logic            fwd_wb_valid;
        logic [RA_W-1:0] fwd_wb_addr;
        logic [XLEN-1:0] fwd_wb_data;
        logic            em_valid;
        logic [XLEN-1:0] em_pc;
        logic [XLEN-1:0] em_ir;
        logic            em_ld;
        logic            em_st;
        logic            em_gr_we;
        logic [XLEN-1:0] em_rkd;
        logic [RA_W-1:0] em_waddr;
        logic [XLEN-1:0] em_alu;
        logic            req_en;
        logic [3:0]      req_we;
        logic [XLEN-1:0] req_addr;
        logic [XLEN-1:0] req_wdata;
        logic            data_ready;
        logic            data_valid;
        logic [XLEN-1:0] read_data;
        logic            wb_valid;
        logic [XLEN-1:0] wb_pc;
        logic [XLEN-1:0] wb_ir;
        logic            wb_gr_we;
        logic [RA_W-1:0] wb_waddr;
        logic [XLEN-1:0] wb_wdata;
        logic            rf_we;
        logic [RA_W-1:0] rf_waddr;
        logic [XLEN-1:0] rf_wdata;

        ex_stage u_ex (.*);

        mem_stage u_mem (.*);

        wb_stage u_wb (.*);

        reg_file u_rf (
                .clk    (clk),
                .rst    (rst),
                .raddr1 (rf_raddr1),
                .raddr2 (rf_raddr2),
                .rdata1 (rf_rdata1),
                .rdata2 (rf_rdata2),
                .we     (rf_we),
                .waddr  (rf_waddr),
                .wdata  (rf_wdata)
        );

        data_ram u_ram (.*);

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
        output logic clk,
        output logic rst
);

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // reset is released 1 ns after the third rising edge.
        initial begin
                rst = 1'b1;
                repeat (3) @(posedge clk);
                #1 rst = 1'b0;
        end

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker import isa_pkg::*, pipe_pkg::*; #(
        parameter int N = 1
) (
        input  logic            clk,
        input  logic            rst,
        input  logic            commit_valid,
        input  logic [XLEN-1:0] commit_pc,
        input  logic [RA_W-1:0] commit_rd,
        input  logic            commit_we,
        input  logic [XLEN-1:0] commit_wdata,
        input  logic [XLEN-1:0] prog_pc [N],
        input  logic [XLEN-1:0] prog_ir [N],
        input  logic [XLEN-1:0] prog_exp [N],
        output int              errors,
        output int              commits,
        output logic            all_done
);

        logic [XLEN-1:0] model_rf [NREGS];
        logic [XLEN-1:0] commit_rf [NREGS];
        logic [XLEN-1:0] model_mem [RAM_WORDS];
        int              since_rst;
        logic            exp_we;
        logic [XLEN-1:0] exp_val;
        inst_u           cur;

        function automatic logic [XLEN-1:0] alu(input alu_op_t op,
                                                input logic [XLEN-1:0] a, b);
                case (op)
                        ALU_SUB: return a - b;
                        ALU_AND: return a & b;
                        ALU_OR:  return a | b;
                        default: return a + b;
                endcase
        endfunction

        function automatic logic [XLEN-1:0] read_reg(input logic [RA_W-1:0] r);
                return (r == '0) ? '0 : model_rf[r];
        endfunction

        // executes one instruction on the model and returns what its commit must show.
        task automatic run_model(input inst_u ir, output logic we, output logic [XLEN-1:0] val);
                logic [XLEN-1:0] a;
                logic [XLEN-1:0] b;
                logic [XLEN-1:0] addr;
                a    = read_reg(ir.r3.rj);
                b    = read_reg(ir.r3.rk);
                addr = a + {{(XLEN - 12){ir.ri12.si12[11]}}, ir.ri12.si12};
                we   = (ir.r3.rd != '0);
                case (ir.r3.op)
                        OP_ADD_W: val = alu(ALU_ADD, a, b);
                        OP_SUB_W: val = alu(ALU_SUB, a, b);
                        OP_AND:   val = alu(ALU_AND, a, b);
                        OP_OR:    val = alu(ALU_OR, a, b);
                        default:  val = addr; // every 2RI12 op forms rj plus the immediate.
                endcase
                if (ir.ri12.op == OP_LD_W)
                        val = model_mem[addr[RAM_AW+1:2]];
                if (ir.ri12.op == OP_ST_W) begin
                        model_mem[addr[RAM_AW+1:2]] = read_reg(ir.ri12.rd);
                        we = 1'b0;
                end
                if (we)
                        model_rf[ir.r3.rd] = val;
        endtask

        task automatic compare_field(input string name, input logic [XLEN-1:0] exp, got);
                if (got !== exp) begin
                        errors++;
                        $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
                end
        endtask

        task automatic compare_final();
                for (int r = 1; r < NREGS; r++)
                        compare_field($sformatf("final r%0d", r), model_rf[r], commit_rf[r]);
                all_done = 1'b1;
        endtask

        initial begin
                errors    = 0;
                commits   = 0;
                all_done  = 1'b0;
                since_rst = 0;
                for (int r = 0; r < NREGS; r++) begin
                        model_rf[r]  = '0;
                        commit_rf[r] = '0;
                end
                for (int w = 0; w < RAM_WORDS; w++)
                        model_mem[w] = '0;
        end

        // commit outputs are registered, so the falling edge sees them settled.
        always @(negedge clk) begin
                if (commit_valid !== 1'b0 && (rst || since_rst < 2)) begin
                        errors++;
                        $display("commit_valid was high at %0t, during or right after reset", $time);
                end else if (commit_valid === 1'b1) begin
                        if (commits >= N) begin
                                errors++;
                                $display("an extra commit at pc %h came after the whole table", commit_pc);
                        end else begin
                                cur = prog_ir[commits];
                                run_model(cur, exp_we, exp_val);
                                compare_field("commit_pc", prog_pc[commits], commit_pc);
                                compare_field("commit_rd", XLEN'(cur.r3.rd), XLEN'(commit_rd));
                                compare_field("commit_we", XLEN'(exp_we), XLEN'(commit_we));
                                compare_field("commit_wdata", exp_val, commit_wdata);
                                compare_field($sformatf("prog_exp[%0d]", commits),
                                              prog_exp[commits], exp_val);
                                if (commit_we === 1'b1)
                                        commit_rf[commit_rd] = commit_wdata;
                                commits++;
                                if (commits == N)
                                        compare_final();
                        end
                end
                if (rst)
                        since_rst = 0;
                else if (since_rst < 2)
                        since_rst++;
        end

endmodule

// File: tb_la_backend.sv
`timescale 1ns/1ps

module tb_la_backend import isa_pkg::*, pipe_pkg::*; ();

        localparam int              N         = 22;
        localparam logic [XLEN-1:0] PC_BASE   = 32'h1c00_0000;
        localparam int              WD_CYCLES = N * (LAT_MAX + 6) + 50;

        logic            clk;
        logic            rst;
        logic            issue_valid;
        logic [XLEN-1:0] issue_pc;
        logic [XLEN-1:0] issue_ir;
        logic            issue_allowin;
        logic            commit_valid;
        logic [XLEN-1:0] commit_pc;
        logic [RA_W-1:0] commit_rd;
        logic            commit_we;
        logic [XLEN-1:0] commit_wdata;
        logic [XLEN-1:0] prog_pc [N];
        logic [XLEN-1:0] prog_ir [N];
        logic [XLEN-1:0] prog_exp [N];
        int              n_loaded;
        int              chk_errors;
        int              drv_errors;
        int              commits;
        int              gap;
        logic            all_done;

        tb_clock u_clk (
                .clk (clk),
                .rst (rst)
        );

        la_backend u_dut (.*);

        tb_checker #(.N(N)) u_chk (
                .clk          (clk),
                .rst          (rst),
                .commit_valid (commit_valid),
                .commit_pc    (commit_pc),
                .commit_rd    (commit_rd),
                .commit_we    (commit_we),
                .commit_wdata (commit_wdata),
                .prog_pc      (prog_pc),
                .prog_ir      (prog_ir),
                .prog_exp     (prog_exp),
                .errors       (chk_errors),
                .commits      (commits),
                .all_done     (all_done)
        );

        function automatic logic [XLEN-1:0] enc_r3(input logic [16:0] op,
                                                   input logic [4:0] rd, rj, rk);
                inst_u w;
                w.r3.op = op;
                w.r3.rk = rk;
                w.r3.rj = rj;
                w.r3.rd = rd;
                return w;
        endfunction

        function automatic logic [XLEN-1:0] enc_ri12(input logic [9:0] op,
                                                     input logic [4:0] rd, rj,
                                                     input logic [11:0] si);
                inst_u w;
                w.ri12.op   = op;
                w.ri12.si12 = si;
                w.ri12.rj   = rj;
                w.ri12.rd   = rd;
                return w;
        endfunction

        task automatic add_entry(input logic [XLEN-1:0] ir, input logic [XLEN-1:0] exp);
                prog_pc[n_loaded]  = PC_BASE + 4 * n_loaded;
                prog_ir[n_loaded]  = ir;
                prog_exp[n_loaded] = exp;
                n_loaded++;
        endtask

        // each entry holds an instruction word and its expected commit_wdata (the address for st.w).
        task automatic load_program();
                n_loaded = 0;
                add_entry(enc_ri12(OP_ADDI_W, 1, 0, 12'd5), 32'h0000_0005);
                add_entry(enc_ri12(OP_ADDI_W, 2, 0, 12'hffd), 32'hffff_fffd);
                add_entry(enc_r3(OP_ADD_W, 3, 1, 2), 32'h0000_0002);
                add_entry(enc_r3(OP_SUB_W, 4, 3, 1), 32'hffff_fffd);
                add_entry(enc_r3(OP_AND, 5, 4, 1), 32'h0000_0005);
                add_entry(enc_r3(OP_OR, 6, 5, 2), 32'hffff_fffd);
                add_entry(enc_ri12(OP_ADDI_W, 7, 0, 12'h7ff), 32'h0000_07ff);
                add_entry(enc_ri12(OP_ADDI_W, 8, 0, 12'h040), 32'h0000_0040);
                add_entry(enc_ri12(OP_ST_W, 7, 8, 12'h000), 32'h0000_0040);
                add_entry(enc_ri12(OP_LD_W, 9, 8, 12'h000), 32'h0000_07ff);
                add_entry(enc_ri12(OP_ADDI_W, 10, 9, 12'd1), 32'h0000_0800);
                add_entry(enc_ri12(OP_ST_W, 6, 8, 12'h004), 32'h0000_0044);
                add_entry(enc_ri12(OP_LD_W, 11, 8, 12'h004), 32'hffff_fffd);
                add_entry(enc_r3(OP_ADD_W, 12, 11, 9), 32'h0000_07fc);
                add_entry(enc_ri12(OP_ADDI_W, 0, 1, 12'd9), 32'h0000_000e);
                add_entry(enc_r3(OP_ADD_W, 13, 0, 1), 32'h0000_0005);
                add_entry(enc_ri12(OP_LD_W, 14, 8, 12'h008), 32'h0000_0000);
                add_entry(enc_r3(OP_OR, 15, 14, 10), 32'h0000_0800);
                add_entry(enc_r3(OP_SUB_W, 16, 15, 12), 32'h0000_0004);
                add_entry(enc_ri12(OP_ST_W, 16, 0, 12'h080), 32'h0000_0080);
                add_entry(enc_ri12(OP_LD_W, 17, 0, 12'h080), 32'h0000_0004);
                add_entry(enc_r3(OP_AND, 18, 17, 16), 32'h0000_0004);
        endtask

        // holds the entry until allowin is seen high before a rising edge.
        task automatic offer(input int i);
                logic accepted;
                issue_valid = 1'b1;
                issue_pc    = prog_pc[i];
                issue_ir    = prog_ir[i];
                accepted    = 1'b0;
                while (!accepted) begin
                        @(negedge clk);
                        accepted = issue_allowin;
                        @(posedge clk);
                        #1;
                end
                issue_valid = 1'b0;
        endtask

        task automatic print_counts();
                $display("errors: %0d, commits: %0d of %0d", chk_errors + drv_errors, commits, N);
        endtask

        initial begin
                issue_valid = 1'b0;
                issue_pc    = '0;
                issue_ir    = '0;
                drv_errors  = 0;
                gap         = $urandom(17761); // seeds the generator for the idle gaps.
                load_program();
                @(negedge rst);
                @(negedge clk);
                if (issue_allowin !== 1'b1) begin
                        drv_errors++;
                        $display("issue_allowin is not high right after reset");
                end
                @(posedge clk);
                #1;
                for (int i = 0; i < N; i++) begin
                        gap = $urandom % 3;
                        repeat (gap) begin
                                @(posedge clk);
                                #1;
                        end
                        offer(i);
                end
                wait (all_done === 1'b1);
                repeat (5) @(posedge clk); // room for a stray extra commit to show up.
                print_counts();
                if (chk_errors + drv_errors == 0)
                        $display("TEST PASSED");
                else
                        $display("TEST FAILED");
                $finish;
        end

        initial begin
                repeat (WD_CYCLES + 3) @(posedge clk);
                $display("watchdog expired with only %0d of %0d table entries committed", commits, N);
                print_counts();
                $display("TEST FAILED");
                $finish;
        end

endmodule

// File: la_backend.f
isa_pkg.sv
pipe_pkg.sv
ex_stage.sv
mem_stage.sv
wb_stage.sv
reg_file.sv
data_ram.sv
la_backend.sv
tb_clock.sv
tb_checker.sv
tb_la_backend.sv
